//--- Makefile
# Verilator build and run of the CPU testbench.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= slurm16_cpu_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard rtl/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source, header or the file list changes.
$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, so the simulator's own exit status is not used.
run: $(SIM)
	$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx 'TEST PASS' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- rtl/slurm16_cpu_alu.sv
// Combinational ALU with the Z, C, S and V flag register.
// The sequencer raises flags_load on the edge that retires an ALU instruction.

`timescale 1ns/1ps
`include "slurm16_settings.svh"

module slurm16_cpu_alu (
	input  logic                     CLK,
	input  logic                     reset,
	input  logic [`SLURM16_BITS-1:0] alu_a,
	input  logic [`SLURM16_BITS-1:0] alu_b,
	input  slurm16_pkg::alu_op_t     alu_op,
	input  logic                     flags_load,
	output logic [`SLURM16_BITS-1:0] alu_out,
	output logic                     flag_z,
	output logic                     flag_c,
	output logic                     flag_s,
	output logic                     flag_v
);
	import slurm16_pkg::*;

	localparam int MSB = `SLURM16_BITS - 1;

	logic [`SLURM16_BITS:0] sum;  // Top bit is the carry out.
	logic [`SLURM16_BITS:0] diff; // Top bit is set when there is no borrow.
	logic                   c_next;
	logic                   v_next;

	assign sum  = {1'b0, alu_a} + {1'b0, alu_b};
	assign diff = {1'b0, alu_a} + {1'b0, ~alu_b} + {{`SLURM16_BITS{1'b0}}, 1'b1};

	always_comb begin
		c_next = 1'b0; // Logic operations and shifts clear C and V.
		v_next = 1'b0;
		case (alu_op)
			alu_add: begin
				alu_out = sum[MSB:0];
				c_next  = sum[`SLURM16_BITS];
				v_next  = (alu_a[MSB] == alu_b[MSB]) && (sum[MSB] != alu_a[MSB]);
			end
			alu_sub: begin
				alu_out = diff[MSB:0];
				c_next  = diff[`SLURM16_BITS];
				v_next  = (alu_a[MSB] != alu_b[MSB]) && (diff[MSB] != alu_a[MSB]);
			end
			alu_and: alu_out = alu_a & alu_b;
			alu_or:  alu_out = alu_a | alu_b;
			alu_xor: alu_out = alu_a ^ alu_b;
			alu_shr: alu_out = {1'b0, alu_a[MSB:1]}; // The shifted-out bit is dropped.
			default: alu_out = alu_a;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			flag_z <= 1'b0;
			flag_c <= 1'b0;
			flag_s <= 1'b0;
			flag_v <= 1'b0;
		end else if (flags_load) begin
			flag_z <= (alu_out == '0);
			flag_c <= c_next;
			flag_s <= alu_out[MSB];
			flag_v <= v_next;
		end
	end

endmodule

//--- rtl/slurm16_cpu_port_interface.sv
// APB master for the I/O ports of the CPU.
// Turns a one-cycle port request into a setup phase and an access phase held until pready.

`timescale 1ns/1ps
`include "slurm16_settings.svh"

module slurm16_cpu_port_interface (
	input  logic                             CLK,
	input  logic                             reset,
	input  logic                             port_req,
	input  logic                             port_wr_req,
	input  logic [`SLURM16_ADDRESS_BITS-1:0] port_addr_req,
	input  logic [`SLURM16_BITS-1:0]         port_wdata_req,
	output logic                             port_done,
	output logic [`SLURM16_BITS-1:0]         port_rdata_resp,
	output logic [`SLURM16_ADDRESS_BITS-1:0] port_paddr,
	output logic                             port_psel,
	output logic                             port_penable,
	output logic                             port_pwrite,
	output logic [`SLURM16_BITS-1:0]         port_pwdata,
	input  logic [`SLURM16_BITS-1:0]         port_prdata,
	input  logic                             port_pready
);

	typedef enum logic [1:0] {apb_idle, apb_setup, apb_access} apb_state_t;

	apb_state_t state;

	// The transfer completes on the edge where pready is seen in the access phase.
	assign port_done       = (state == apb_access) && port_pready;
	assign port_rdata_resp = port_prdata;

	always_ff @(posedge CLK) begin
		if (reset) begin
			state        <= apb_idle;
			port_psel    <= 1'b0;
			port_penable <= 1'b0;
		end else begin
			case (state)
				apb_idle: begin
					if (port_req) begin
						port_paddr  <= port_addr_req; // Held until the transfer ends.
						port_pwrite <= port_wr_req;
						port_pwdata <= port_wdata_req;
						port_psel   <= 1'b1;
						state       <= apb_setup;
					end
				end
				apb_setup: begin
					port_penable <= 1'b1;
					state        <= apb_access;
				end
				apb_access: begin
					if (port_pready) begin
						port_psel    <= 1'b0;
						port_penable <= 1'b0;
						state        <= apb_idle;
					end
				end
				default: state <= apb_idle;
			endcase
		end
	end

endmodule

//--- rtl/slurm16_cpu_registers.sv
// General purpose register file of the CPU.
// Two combinational read ports feed the sequencer, one write port takes the write-back.

`timescale 1ns/1ps
`include "slurm16_settings.svh"

module slurm16_cpu_registers (
	input  logic                              CLK,
	input  logic [`SLURM16_REGISTER_BITS-1:0] reg_a_sel,
	input  logic [`SLURM16_REGISTER_BITS-1:0] reg_b_sel,
	input  logic [`SLURM16_REGISTER_BITS-1:0] reg_wr_sel,
	input  logic                              reg_wr_en,
	input  logic [`SLURM16_BITS-1:0]          reg_wr_data,
	output logic [`SLURM16_BITS-1:0]          reg_a,
	output logic [`SLURM16_BITS-1:0]          reg_b
);

	// Contents are undefined after reset until a program writes them.
	logic [`SLURM16_BITS-1:0] regs [0:(1 << `SLURM16_REGISTER_BITS)-1];

	always_ff @(posedge CLK) begin
		if (reg_wr_en) begin
			regs[reg_wr_sel] <= reg_wr_data;
		end
	end

	assign reg_a = regs[reg_a_sel];
	assign reg_b = regs[reg_b_sel]; // Store data and second ALU operand.

endmodule

//--- rtl/slurm16_cpu_sequencer.sv
// Fetch, decode and execute control of the CPU, one instruction in flight at a time.
// Owns the pc, the instruction register and the memory request, and starts port transfers.

`timescale 1ns/1ps
`include "slurm16_settings.svh"

module slurm16_cpu_sequencer (
	input  logic                              CLK,
	input  logic                              reset,
	output logic [`SLURM16_ADDRESS_BITS-1:0]  memory_address,
	input  logic [`SLURM16_BITS-1:0]          memory_in,
	output logic [`SLURM16_BITS-1:0]          memory_out,
	output logic                              memory_rd,
	output logic                              memory_wr,
	input  logic                              memory_success,
	output logic [`SLURM16_REGISTER_BITS-1:0] reg_a_sel,
	output logic [`SLURM16_REGISTER_BITS-1:0] reg_b_sel,
	input  logic [`SLURM16_BITS-1:0]          reg_a,
	input  logic [`SLURM16_BITS-1:0]          reg_b,
	output logic                              reg_wr_en,
	output logic [`SLURM16_REGISTER_BITS-1:0] reg_wr_sel,
	output logic [`SLURM16_BITS-1:0]          reg_wr_data,
	output slurm16_pkg::alu_op_t              alu_op,
	output logic [`SLURM16_BITS-1:0]          alu_a,
	output logic [`SLURM16_BITS-1:0]          alu_b,
	input  logic [`SLURM16_BITS-1:0]          alu_out,
	output logic                              flags_load,
	input  logic                              flag_z,
	input  logic                              flag_c,
	input  logic                              flag_s,
	input  logic                              flag_v,
	output logic                              port_req,
	output logic                              port_wr_req,
	output logic [`SLURM16_ADDRESS_BITS-1:0]  port_addr_req,
	output logic [`SLURM16_BITS-1:0]          port_wdata_req,
	input  logic                              port_done,
	input  logic [`SLURM16_BITS-1:0]          port_rdata_resp,
	output logic                              halted
);
	import slurm16_pkg::*;

	seq_state_t                      state;
	logic [`SLURM16_ADDRESS_BITS-1:0] pc; // Points past the instruction in ir once it is fetched.
	logic [`SLURM16_BITS-1:0]         ir;
	opcode_t                         opcode;
	cond_t                           cond;
	logic [7:0]                      imm;
	logic                            is_alu;
	logic                            cond_pass;
	logic [`SLURM16_ADDRESS_BITS-1:0] next_pc;

	assign opcode = opcode_t'(ir[15:12]);
	assign cond   = cond_t'(ir[10:8]);
	assign imm    = ir[7:0];
	assign is_alu = opcode inside {op_add, op_sub, op_and, op_or, op_xor, op_shr};

	always_comb begin
		case (cond)
			cond_z:  cond_pass = flag_z;
			cond_nz: cond_pass = !flag_z;
			cond_c:  cond_pass = flag_c;
			cond_nc: cond_pass = !flag_c;
			cond_s:  cond_pass = flag_s;
			cond_ns: cond_pass = !flag_s;
			cond_v:  cond_pass = flag_v;
			default: cond_pass = 1'b1;
		endcase
	end

	// A taken branch lands at its own address plus one plus the signed offset.
	assign next_pc = (opcode == op_br && cond_pass) ?
		pc + {{(`SLURM16_ADDRESS_BITS - 8){imm[7]}}, imm} : pc;

	always_comb begin
		case (opcode)
			op_add:  alu_op = alu_add;
			op_sub:  alu_op = alu_sub;
			op_and:  alu_op = alu_and;
			op_or:   alu_op = alu_or;
			op_xor:  alu_op = alu_xor;
			op_shr:  alu_op = alu_shr;
			default: alu_op = alu_pass;
		endcase
	end

	// op_out reads its data from the rd field.
	assign reg_a_sel  = (opcode == op_out) ? ir[11:8] : ir[7:4];
	assign reg_b_sel  = ir[3:0];
	assign alu_a      = reg_a;
	assign alu_b      = reg_b;
	assign flags_load = (state == st_execute) && is_alu;

	assign reg_wr_sel = ir[11:8];
	assign reg_wr_en  = ((state == st_execute) && (opcode == op_ldi || is_alu)) ||
		((state == st_memory) && (opcode == op_ld) && memory_success) ||
		((state == st_port) && (opcode == op_in) && port_done);

	always_comb begin
		case (opcode)
			op_ldi:  reg_wr_data = {{(`SLURM16_BITS - 8){1'b0}}, imm};
			op_ld:   reg_wr_data = memory_in;
			op_in:   reg_wr_data = port_rdata_resp;
			default: reg_wr_data = alu_out;
		endcase
	end

	assign port_req       = (state == st_execute) && (opcode == op_in || opcode == op_out);
	assign port_wr_req    = (opcode == op_out);
	assign port_addr_req  = {{(`SLURM16_ADDRESS_BITS - 8){1'b0}}, imm};
	assign port_wdata_req = reg_a;

	always_ff @(posedge CLK) begin
		if (reset) begin
			state     <= st_fetch;
			pc        <= '0;
			memory_rd <= 1'b0;
			memory_wr <= 1'b0;
			halted    <= 1'b0;
		end else begin
			case (state)
				st_fetch: begin
					if (!memory_rd) begin
						memory_rd      <= 1'b1; // Only the first fetch after reset starts here.
						memory_address <= pc;
					end else if (memory_success) begin
						memory_rd <= 1'b0;
						ir        <= memory_in;
						pc        <= pc + {{(`SLURM16_ADDRESS_BITS - 1){1'b0}}, 1'b1};
						state     <= st_execute;
					end
				end
				st_execute: begin
					case (opcode)
						op_ld, op_st: begin
							memory_address <= reg_a;
							memory_out     <= reg_b;
							memory_rd      <= (opcode == op_ld);
							memory_wr      <= (opcode == op_st);
							state          <= st_memory;
						end
						op_in, op_out: state <= st_port;
						op_halt: begin
							halted <= 1'b1;
							state  <= st_halted;
						end
						default: begin
							// The next fetch is requested on the same edge.
							pc             <= next_pc;
							memory_rd      <= 1'b1;
							memory_address <= next_pc;
							state          <= st_fetch;
						end
					endcase
				end
				st_memory: begin
					if (memory_success) begin
						memory_wr      <= 1'b0;
						memory_rd      <= 1'b1;
						memory_address <= pc;
						state          <= st_fetch;
					end
				end
				st_port: begin
					if (port_done) begin
						memory_rd      <= 1'b1;
						memory_address <= pc;
						state          <= st_fetch;
					end
				end
				default: state <= st_halted; // Only reset leaves the halted state.
			endcase
		end
	end

endmodule

//--- rtl/slurm16_cpu_top.sv
// Top level of the CPU, tying the sequencer to the register file, ALU and APB port master.
// External memory uses request-until-success handshaking and I/O goes over APB.

`timescale 1ns/1ps
`include "slurm16_settings.svh"

module slurm16_cpu_top (
	input  logic                             CLK,
	input  logic                             reset,
	output logic [`SLURM16_ADDRESS_BITS-1:0] memory_address,
	input  logic [`SLURM16_BITS-1:0]         memory_in,
	output logic [`SLURM16_BITS-1:0]         memory_out,
	output logic                             memory_rd,
	output logic                             memory_wr,
	input  logic                             memory_success,
	output logic [`SLURM16_ADDRESS_BITS-1:0] port_paddr,
	output logic                             port_psel,
	output logic                             port_penable,
	output logic                             port_pwrite,
	output logic [`SLURM16_BITS-1:0]         port_pwdata,
	input  logic [`SLURM16_BITS-1:0]         port_prdata,
	input  logic                             port_pready,
	output logic                             halted
);
	import slurm16_pkg::*;

	logic [`SLURM16_REGISTER_BITS-1:0] reg_a_sel;
	logic [`SLURM16_REGISTER_BITS-1:0] reg_b_sel;
	logic [`SLURM16_REGISTER_BITS-1:0] reg_wr_sel;
	logic [`SLURM16_BITS-1:0]          reg_a;
	logic [`SLURM16_BITS-1:0]          reg_b;
	logic                              reg_wr_en;
	logic [`SLURM16_BITS-1:0]          reg_wr_data;

	alu_op_t                           alu_op;
	logic [`SLURM16_BITS-1:0]          alu_a;
	logic [`SLURM16_BITS-1:0]          alu_b;
	logic [`SLURM16_BITS-1:0]          alu_out;
	logic                              flags_load;
	logic                              flag_z;
	logic                              flag_c;
	logic                              flag_s;
	logic                              flag_v;

	logic                              port_req;    // One-cycle start of a port transfer.
	logic                              port_wr_req;
	logic [`SLURM16_ADDRESS_BITS-1:0]  port_addr_req;
	logic [`SLURM16_BITS-1:0]          port_wdata_req;
	logic                              port_done;
	logic [`SLURM16_BITS-1:0]          port_rdata_resp;

	slurm16_cpu_sequencer seq0 (
		.CLK(CLK), .reset(reset),
		.memory_address(memory_address), .memory_in(memory_in), .memory_out(memory_out),
		.memory_rd(memory_rd), .memory_wr(memory_wr), .memory_success(memory_success),
		.reg_a_sel(reg_a_sel), .reg_b_sel(reg_b_sel), .reg_a(reg_a), .reg_b(reg_b),
		.reg_wr_en(reg_wr_en), .reg_wr_sel(reg_wr_sel), .reg_wr_data(reg_wr_data),
		.alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b), .alu_out(alu_out),
		.flags_load(flags_load),
		.flag_z(flag_z), .flag_c(flag_c), .flag_s(flag_s), .flag_v(flag_v),
		.port_req(port_req), .port_wr_req(port_wr_req), .port_addr_req(port_addr_req),
		.port_wdata_req(port_wdata_req), .port_done(port_done),
		.port_rdata_resp(port_rdata_resp), .halted(halted)
	);

	slurm16_cpu_registers reg0 (
		.CLK(CLK),
		.reg_a_sel(reg_a_sel), .reg_b_sel(reg_b_sel), .reg_wr_sel(reg_wr_sel),
		.reg_wr_en(reg_wr_en), .reg_wr_data(reg_wr_data),
		.reg_a(reg_a), .reg_b(reg_b)
	);

	slurm16_cpu_alu alu0 (
		.CLK(CLK), .reset(reset),
		.alu_a(alu_a), .alu_b(alu_b), .alu_op(alu_op), .flags_load(flags_load),
		.alu_out(alu_out),
		.flag_z(flag_z), .flag_c(flag_c), .flag_s(flag_s), .flag_v(flag_v)
	);

	slurm16_cpu_port_interface prt0 (
		.CLK(CLK), .reset(reset),
		.port_req(port_req), .port_wr_req(port_wr_req), .port_addr_req(port_addr_req),
		.port_wdata_req(port_wdata_req), .port_done(port_done),
		.port_rdata_resp(port_rdata_resp),
		.port_paddr(port_paddr), .port_psel(port_psel), .port_penable(port_penable),
		.port_pwrite(port_pwrite), .port_pwdata(port_pwdata),
		.port_prdata(port_prdata), .port_pready(port_pready)
	);

endmodule

//--- rtl/slurm16_pkg.sv
// Types shared by the CPU blocks and the testbench.
// Import it where opcodes, ALU operations, branch conditions or sequencer states are used.

package slurm16_pkg;

	// Top nibble of every instruction.
	typedef enum logic [3:0] {
		op_nop  = 4'h0,
		op_ldi  = 4'h1,
		op_add  = 4'h2,
		op_sub  = 4'h3,
		op_and  = 4'h4,
		op_or   = 4'h5,
		op_xor  = 4'h6,
		op_shr  = 4'h7,
		op_ld   = 4'h8,
		op_st   = 4'h9,
		op_in   = 4'ha,
		op_out  = 4'hb,
		op_br   = 4'hc,
		op_halt = 4'hd
	} opcode_t;

	typedef enum logic [2:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_shr, alu_pass
	} alu_op_t;

	// Taken from the low three bits of the rd field of a branch.
	typedef enum logic [2:0] {
		cond_always, cond_z, cond_nz, cond_c, cond_nc, cond_s, cond_ns, cond_v
	} cond_t;

	typedef enum logic [2:0] {
		st_fetch, st_execute, st_memory, st_port, st_halted
	} seq_state_t;

endpackage

//--- rtl/slurm16_settings.svh
// Width settings shared by every CPU block.
// Include this file in any source that sizes a data, address or register select bus.

`ifndef SLURM16_SETTINGS_SVH
`define SLURM16_SETTINGS_SVH

// Machine word and instruction width.
`define SLURM16_BITS 16

// Memory and port address width.
`define SLURM16_ADDRESS_BITS 16

// Register select width, which gives 16 general purpose registers.
`define SLURM16_REGISTER_BITS 4

`endif

//--- sources.f
+incdir+rtl
rtl/slurm16_pkg.sv
rtl/slurm16_cpu_registers.sv
rtl/slurm16_cpu_alu.sv
rtl/slurm16_cpu_sequencer.sv
rtl/slurm16_cpu_port_interface.sv
rtl/slurm16_cpu_top.sv
tests/slurm16_cpu_tb.sv

//--- tests/slurm16_cpu_stimulus.hex
// Program words from 0x00, APB read responses from 0x80, expected port writes at 0xC0
// as a count then address and data pairs, program length at 0xF8, memory checks from 0xF9.
@00
115a 123c 2312 b310 3412 b411 4512 b512
5612 b613 6712 b714 7810 b815 19a1 1ab2
3b11 c101 b920 ba30 c201 b921 ba31 c301
b922 ba32 c401 b923 ba33 1c00 1d01 3ecd
c501 b924 ba34 c601 b925 ba35 c201 b926
ba36 7fe0 c701 b927 ba37 2ffd c701 b928
ba38 c001 b929 ba39 1270 9023 8520 b540
1671 906e 8760 b741 a802 b850 a905 2a89
ba51 d000
@80
1234 abcd 0f0f c3c3 5555 0aa0 7e7e 0001
@c0
0018
0010 0096 0011 001e 0012 0018 0013 007e
0014 0066 0015 002d 0030 00b2 0021 00a1
0031 00b2 0032 00b2 0023 00a1 0033 00b2
0034 00b2 0025 00a1 0035 00b2 0036 00b2
0027 00a1 0037 00b2 0038 00b2 0039 00b2
0040 0096 0041 ffff 0050 0f0f 0051 19af
@f8
0042
0002 0070 0096 0071 ffff

//--- tests/slurm16_cpu_tb.sv
// Testbench for the CPU. Runs the program from the stimulus file against a wait-state memory
// model and an APB slave model, then checks the port writes, memory contents and halted.

`timescale 1ns/1ps
`include "slurm16_settings.svh"

module slurm16_cpu_tb;

	logic                             CLK;
	logic                             reset;
	logic [`SLURM16_ADDRESS_BITS-1:0] memory_address;
	logic [`SLURM16_BITS-1:0]         memory_in;
	logic [`SLURM16_BITS-1:0]         memory_out;
	logic                             memory_rd;
	logic                             memory_wr;
	logic                             memory_success;
	logic [`SLURM16_ADDRESS_BITS-1:0] port_paddr;
	logic                             port_psel;
	logic                             port_penable;
	logic                             port_pwrite;
	logic [`SLURM16_BITS-1:0]         port_pwdata;
	logic [`SLURM16_BITS-1:0]         port_prdata;
	logic                             port_pready;
	logic                             halted;

	// Program at 0x00, read responses at 0x80, expected writes at 0xC0, run data from 0xF8.
	logic [`SLURM16_BITS-1:0]         image [0:255];
	logic [31:0]                      rng_state;
	logic                             mem_pending;
	logic [`SLURM16_ADDRESS_BITS-1:0] mem_addr;
	logic [`SLURM16_BITS-1:0]         mem_data;
	logic                             mem_write;
	int                               mem_wait;
	int                               apb_wait;
	logic [`SLURM16_ADDRESS_BITS-1:0] apb_addr;
	logic [`SLURM16_BITS-1:0]         writes_seen;
	int                               cycle_limit;
	int                               cycles;

	slurm16_cpu_top slurm16_cpu_top_i (.*);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	function automatic logic [31:0] next_random(input logic [31:0] value);
		logic [31:0] x;
		x = value ^ (value << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_port_write(input logic [`SLURM16_ADDRESS_BITS-1:0] address,
			input logic [`SLURM16_BITS-1:0] data);
		logic [7:0] slot;
		slot = 8'hc1 + {writes_seen[6:0], 1'b0}; // Address and data pairs follow the count.
		if (writes_seen >= image[8'hc0]) begin
			stop_run("the CPU wrote more ports than the stimulus file expects");
		end
		if (address !== image[slot]) begin
			stop_run($sformatf("mismatch at time %0t: port_paddr expected %h got %h",
				$time, image[slot], address));
		end
		if (data !== image[slot + 8'd1]) begin
			stop_run($sformatf("mismatch at time %0t: port_pwdata expected %h got %h",
				$time, image[slot + 8'd1], data));
		end
		writes_seen = writes_seen + {{(`SLURM16_BITS - 1){1'b0}}, 1'b1};
	endtask

	task automatic check_memory_word(input logic [`SLURM16_ADDRESS_BITS-1:0] address,
			input logic [`SLURM16_BITS-1:0] expected);
		if (image[address[7:0]] !== expected) begin
			stop_run($sformatf("mismatch at time %0t: memory[%h] expected %h got %h",
				$time, address, expected, image[address[7:0]]));
		end
	endtask

	task automatic check_halted(input logic actual);
		if (actual !== 1'b1) begin
			stop_run($sformatf("mismatch at time %0t: halted expected 1 got %b", $time, actual));
		end
	endtask

	task automatic serve_memory();
		logic [7:0] word;
		if (memory_success) begin
			memory_success = 1'b0; // The last edge completed the request.
			mem_pending    = 1'b0;
		end
		if (memory_rd || memory_wr) begin
			if (memory_rd && memory_wr) begin
				stop_run("memory_rd and memory_wr are high together");
			end
			if (|memory_address[`SLURM16_ADDRESS_BITS-1:8]) begin
				stop_run("memory access outside the 256-word image");
			end
			if (!mem_pending) begin
				mem_pending = 1'b1;
				mem_addr    = memory_address;
				mem_data    = memory_out;
				mem_write   = memory_wr;
				rng_state   = next_random(rng_state);
				mem_wait    = int'(rng_state % 32'd4);
			end else if (memory_address !== mem_addr || memory_wr !== mem_write ||
					(mem_write && memory_out !== mem_data)) begin
				stop_run("memory request changed while it was still pending");
			end
			word = mem_addr[7:0];
			if (mem_wait == 0) begin
				if (mem_write) begin
					image[word] = mem_data;
				end else begin
					memory_in = image[word];
				end
				memory_success = 1'b1;
			end else begin
				mem_wait--;
			end
		end
	endtask

	task automatic serve_apb();
		if (port_pready) begin
			port_pready = 1'b0;
		end
		if (port_psel && !port_penable) begin
			// The pready delay for this transfer is chosen in the setup phase.
			apb_addr  = port_paddr;
			rng_state = next_random(rng_state);
			apb_wait  = int'(rng_state % 32'd3);
		end else if (port_psel && port_penable) begin
			if (port_paddr !== apb_addr) begin
				stop_run("port_paddr changed between the setup and access phases");
			end
			if (apb_wait == 0) begin
				port_pready = 1'b1;
				if (port_pwrite) begin
					check_port_write(port_paddr, port_pwdata);
				end else begin
					port_prdata = image[8'h80 + port_paddr[7:0]]; // Response table lookup.
				end
			end else begin
				apb_wait--;
			end
		end
	endtask

	// The memory and APB slave models drive their outputs a short delay after each rising edge.
	initial begin
		memory_in      = '0;
		memory_success = 1'b0;
		port_prdata    = '0;
		port_pready    = 1'b0;
		rng_state      = 32'hf82c0165;
		mem_pending    = 1'b0;
		writes_seen    = '0;
		forever begin
			@(posedge CLK);
			#2;
			serve_memory();
			serve_apb();
		end
	end

	initial begin
		reset = 1'b1;
		for (int i = 0; i < 256; i++) begin
			image[i[7:0]] = {i[7:0], ~i[7:0]}; // Words the file does not set stay distinct.
		end
		$readmemh("tests/slurm16_cpu_stimulus.hex", image);
		// Up to 8 cycles per instruction, and 14 times the program for executed branches.
		cycle_limit = int'(image[8'hf8]) * 14 * 8 + 200;
		repeat (16) @(posedge CLK);
		#2;
		reset  = 1'b0;
		cycles = 0;
		while (halted !== 1'b1) begin
			@(posedge CLK);
			#2;
			cycles++;
			if (cycles >= cycle_limit) begin
				stop_run("timeout: CPU did not halt");
			end
		end
		repeat (20) begin
			@(posedge CLK);
			#2;
			if (memory_rd || memory_wr || port_psel) begin
				stop_run("a memory or APB request was issued after halt");
			end
			check_halted(halted);
		end
		if (writes_seen !== image[8'hc0]) begin
			stop_run($sformatf("mismatch at time %0t: port write count expected %0d got %0d",
				$time, image[8'hc0], writes_seen));
		end
		for (int k = 0; k < int'(image[8'hf9]); k++) begin
			check_memory_word(image[8'hfa + {k[6:0], 1'b0}], image[8'hfb + {k[6:0], 1'b0}]);
		end
		$display("TEST PASS");
		$finish;
	end

endmodule
